//--- mem_ss_cfg.svh
// Build-time configuration of the memory subsystem control wrapper
// Channel count, synchronizer depth, feature header values and
// register port widths

`ifndef MEM_SS_CFG_SVH
`define MEM_SS_CFG_SVH

// ------------------------------------------------------------
// Memory subsystem geometry
// ------------------------------------------------------------

// Number of memory channels reporting calibration status
`define MEM_SS_NUM_CH       4

// Flop stages on each asynchronous calibration bit
`define MEM_SS_SYNC_STAGES  3

// ------------------------------------------------------------
// Device feature header
// ------------------------------------------------------------

`define MEM_SS_FEAT_ID      12'h00f
`define MEM_SS_FEAT_VER     4'h1

// Byte offset to the next header in the feature list
`define MEM_SS_NEXT_DFH     24'h001000

// Set when this is the last header in the list
`define MEM_SS_EOL          1'b0

// Private feature type
`define MEM_SS_FEAT_TYPE    4'h3

// ------------------------------------------------------------
// Register port
// ------------------------------------------------------------

`define MEM_SS_ADDR_W       3
`define MEM_SS_DATA_W       64

`endif

//--- mem_ss_csr_pkg.sv
// Register block types
// Register address map, feature header and status layouts, and the
// read word that carries either view

`include "mem_ss_cfg.svh"

package mem_ss_csr_pkg;

   // Word addresses of the register block, anything above is unmapped
   typedef enum logic [`MEM_SS_ADDR_W-1:0] {
      CSR_DFH     = 3'd0,
      CSR_STATUS  = 3'd1,
      CSR_SCRATCH = 3'd2,
      CSR_CONTROL = 3'd3
   } csr_addr_e;

   // Device feature header
   typedef struct packed {
      logic [3:0]  feat_type;
      logic [18:0] rsvd;
      logic        eol;
      logic [23:0] next_dfh;
      logic [3:0]  feat_ver;
      logic [11:0] feat_id;
   } dfh_t;

   // Status register, one calibration bit per channel
   typedef struct packed {
      logic [45:0]                   rsvd2;
      logic                          rst_busy;
      logic                          rst_done;
      logic [3:0]                    rsvd1;
      logic [`MEM_SS_NUM_CH-1:0]     cal_fail;
      logic [7-`MEM_SS_NUM_CH:0]     rsvd0;
      logic [`MEM_SS_NUM_CH-1:0]     cal_success;
   } status_t;

   // Read word seen as header, status or plain data
   typedef union packed {
      dfh_t                      dfh;
      status_t                   status;
      logic [`MEM_SS_DATA_W-1:0] raw;
   } csr_word_u;

endpackage

//--- mem_ss_rst_pkg.sv
// Reset sequencer types
// State encoding of the subsystem reset handshake

package mem_ss_rst_pkg;

   // IDLE only exists while reset is held; the sequence leaves it on
   // the first clock after reset
   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      REQ     = 3'd1,
      COLD    = 3'd2,
      RELEASE = 3'd3,
      DONE    = 3'd4
   } rst_state_e;

endpackage

//--- mem_ss_csr_decode.sv
// Register port slave
// Four-phase req/ack handshake, access strobe generation and address
// decode with unmapped address detection

`timescale 1ns/1ns
`include "mem_ss_cfg.svh"

module mem_ss_csr_decode (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        csr_req,
   input  logic                        csr_write,
   input  logic [`MEM_SS_ADDR_W-1:0]   csr_addr,
   input  logic [`MEM_SS_DATA_W-1:0]   csr_wdata,
   output logic                        csr_ack,
   output logic                        csr_err,
   output logic                        acc_stb,
   output logic                        acc_write,
   output mem_ss_csr_pkg::csr_addr_e   acc_sel,
   output logic [`MEM_SS_DATA_W-1:0]   acc_wdata
);

   logic                      busy;
   logic                      start;
   logic                      ack_pend;
   logic                      ack_drop;
   logic                      unmapped;
   logic                      unmapped_q;
   mem_ss_csr_pkg::csr_addr_e addr_dec;

   assign addr_dec = mem_ss_csr_pkg::csr_addr_e'(csr_addr);

   always_comb begin
      case (addr_dec)
         mem_ss_csr_pkg::CSR_DFH,
         mem_ss_csr_pkg::CSR_STATUS,
         mem_ss_csr_pkg::CSR_SCRATCH,
         mem_ss_csr_pkg::CSR_CONTROL: unmapped = 1'b0;
         default:                     unmapped = 1'b1;
      endcase
   end

   // A request is only taken once the previous one has fully closed
   assign busy  = acc_stb | ack_pend | csr_ack;
   assign start = csr_req & ~busy;

   // ------------------------------------------------------------
   // Handshake sequencing
   // ------------------------------------------------------------

   // Strobe, then one cycle for the register block, then ack
   always_ff @(posedge clk) begin
      if (reset) begin
         acc_stb  <= 1'b0;
         ack_pend <= 1'b0;
         ack_drop <= 1'b0;
         csr_ack  <= 1'b0;
         csr_err  <= 1'b0;
      end else begin
         acc_stb  <= start;
         ack_pend <= acc_stb;
         ack_drop <= csr_ack & ~csr_req & ~ack_drop;
         if (ack_pend) begin
            csr_ack <= 1'b1;
            csr_err <= unmapped_q;
         end else if (ack_drop) begin
            csr_ack <= 1'b0;
            csr_err <= 1'b0;
         end
      end
   end

   // Access fields captured with the request
   always_ff @(posedge clk) begin
      if (start) begin
         acc_write  <= csr_write;
         acc_sel    <= addr_dec;
         acc_wdata  <= csr_wdata;
         unmapped_q <= unmapped;
      end
   end

endmodule

//--- mem_ss_rst_seq.sv
// Subsystem reset sequencer
// Request, cold reset, acknowledge and release toward the memory
// subsystem, with done and busy levels for the status register

`timescale 1ns/1ns

module mem_ss_rst_seq (
   input  logic clk,
   input  logic reset,
   input  logic restart,
   input  logic ss_rst_rdy,
   input  logic ss_rst_ack_n,
   output logic ss_rst_req,
   output logic ss_cold_rst_n,
   output logic rst_done,
   output logic rst_busy
);

   mem_ss_rst_pkg::rst_state_e state;
   mem_ss_rst_pkg::rst_state_e state_nxt;

   // ------------------------------------------------------------
   // Next state
   // ------------------------------------------------------------

   always_comb begin
      state_nxt = state;
      case (state)
         mem_ss_rst_pkg::IDLE: begin
            state_nxt = mem_ss_rst_pkg::REQ;
         end
         mem_ss_rst_pkg::REQ: begin
            if (ss_rst_rdy) begin
               state_nxt = mem_ss_rst_pkg::COLD;
            end
         end
         mem_ss_rst_pkg::COLD: begin
            if (!ss_rst_ack_n) begin
               state_nxt = mem_ss_rst_pkg::RELEASE;
            end
         end
         // Wait for the subsystem to withdraw both of its handshake lines
         mem_ss_rst_pkg::RELEASE: begin
            if (!ss_rst_rdy && ss_rst_ack_n) begin
               state_nxt = mem_ss_rst_pkg::DONE;
            end
         end
         mem_ss_rst_pkg::DONE: begin
            if (restart) begin
               state_nxt = mem_ss_rst_pkg::REQ;
            end
         end
         default: begin
            state_nxt = mem_ss_rst_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= mem_ss_rst_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // ------------------------------------------------------------
   // Handshake outputs
   // ------------------------------------------------------------

   // Request stays up through the cold reset phase
   assign ss_rst_req    = (state == mem_ss_rst_pkg::REQ) ||
                          (state == mem_ss_rst_pkg::COLD);
   assign ss_cold_rst_n = (state != mem_ss_rst_pkg::COLD);

   assign rst_busy = (state == mem_ss_rst_pkg::REQ)  ||
                     (state == mem_ss_rst_pkg::COLD) ||
                     (state == mem_ss_rst_pkg::RELEASE);
   assign rst_done = (state == mem_ss_rst_pkg::DONE);

endmodule

//--- mem_ss_csr_regs.sv
// Register block storage
// Scratch register, calibration synchronizer chain, restart control
// and read word assembly

`timescale 1ns/1ns
`include "mem_ss_cfg.svh"

module mem_ss_csr_regs (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        acc_stb,
   input  logic                        acc_write,
   input  mem_ss_csr_pkg::csr_addr_e   acc_sel,
   input  logic [`MEM_SS_DATA_W-1:0]   acc_wdata,
   input  logic [`MEM_SS_NUM_CH-1:0]   cal_success,
   input  logic [`MEM_SS_NUM_CH-1:0]   cal_fail,
   input  logic                        rst_done,
   input  logic                        rst_busy,
   output logic [`MEM_SS_DATA_W-1:0]   csr_rdata,
   output logic                        restart
);

   // Success and fail bits share one chain
   localparam int CAL_W = 2 * `MEM_SS_NUM_CH;

   logic [CAL_W-1:0]           cal_sync [`MEM_SS_SYNC_STAGES];
   logic [`MEM_SS_NUM_CH-1:0]  cal_success_s;
   logic [`MEM_SS_NUM_CH-1:0]  cal_fail_s;
   logic [`MEM_SS_DATA_W-1:0]  scratch;
   logic                       wr_stb;
   mem_ss_csr_pkg::csr_word_u  rd_word;

   // ------------------------------------------------------------
   // Calibration status synchronizers
   // ------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `MEM_SS_SYNC_STAGES; i++) begin
            cal_sync[i] <= '0;
         end
      end else begin
         cal_sync[0] <= {cal_fail, cal_success};
         for (int i = 1; i < `MEM_SS_SYNC_STAGES; i++) begin
            cal_sync[i] <= cal_sync[i-1];
         end
      end
   end

   assign {cal_fail_s, cal_success_s} = cal_sync[`MEM_SS_SYNC_STAGES-1];

   // ------------------------------------------------------------
   // Writes
   // ------------------------------------------------------------

   assign wr_stb = acc_stb & acc_write;

   // Bit 0 of the control register is self clearing, so it lives only
   // as the restart pulse
   always_ff @(posedge clk) begin
      if (reset) begin
         scratch <= '0;
         restart <= 1'b0;
      end else begin
         restart <= wr_stb && (acc_sel == mem_ss_csr_pkg::CSR_CONTROL) && acc_wdata[0];
         if (wr_stb && (acc_sel == mem_ss_csr_pkg::CSR_SCRATCH)) begin
            scratch <= acc_wdata;
         end
      end
   end

   // ------------------------------------------------------------
   // Read word
   // ------------------------------------------------------------

   always_comb begin
      rd_word.raw = '0;
      case (acc_sel)
         mem_ss_csr_pkg::CSR_DFH: begin
            rd_word.dfh.feat_type = `MEM_SS_FEAT_TYPE;
            rd_word.dfh.eol       = `MEM_SS_EOL;
            rd_word.dfh.next_dfh  = `MEM_SS_NEXT_DFH;
            rd_word.dfh.feat_ver  = `MEM_SS_FEAT_VER;
            rd_word.dfh.feat_id   = `MEM_SS_FEAT_ID;
         end
         mem_ss_csr_pkg::CSR_STATUS: begin
            rd_word.status.rst_busy    = rst_busy;
            rd_word.status.rst_done    = rst_done;
            rd_word.status.cal_fail    = cal_fail_s;
            rd_word.status.cal_success = cal_success_s;
         end
         mem_ss_csr_pkg::CSR_SCRATCH: begin
            rd_word.raw = scratch;
         end
         // Control and unmapped addresses read as zero
         default: begin
            rd_word.raw = '0;
         end
      endcase
   end

   // Captured on the strobe and held until the next access
   always_ff @(posedge clk) begin
      if (acc_stb) begin
         csr_rdata <= acc_write ? '0 : rd_word.raw;
      end
   end

endmodule

//--- mem_ss_top.sv
// Memory subsystem control wrapper
// Register port decode, register block and subsystem reset sequencer

`timescale 1ns/1ns
`include "mem_ss_cfg.svh"

module mem_ss_top (
   input  logic                        clk,
   input  logic                        reset,
   // Register port
   input  logic                        csr_req,
   input  logic                        csr_write,
   input  logic [`MEM_SS_ADDR_W-1:0]   csr_addr,
   input  logic [`MEM_SS_DATA_W-1:0]   csr_wdata,
   output logic                        csr_ack,
   output logic [`MEM_SS_DATA_W-1:0]   csr_rdata,
   output logic                        csr_err,
   // Subsystem reset handshake
   output logic                        ss_rst_req,
   output logic                        ss_cold_rst_n,
   input  logic                        ss_rst_rdy,
   input  logic                        ss_rst_ack_n,
   // Calibration status, asynchronous
   input  logic [`MEM_SS_NUM_CH-1:0]   cal_success,
   input  logic [`MEM_SS_NUM_CH-1:0]   cal_fail
);

   logic                       acc_stb;
   logic                       acc_write;
   mem_ss_csr_pkg::csr_addr_e  acc_sel;
   logic [`MEM_SS_DATA_W-1:0]  acc_wdata;
   logic                       restart;
   logic                       rst_done;
   logic                       rst_busy;

   mem_ss_csr_decode csr_decode_inst (
      .clk        (clk),
      .reset      (reset),
      .csr_req    (csr_req),
      .csr_write  (csr_write),
      .csr_addr   (csr_addr),
      .csr_wdata  (csr_wdata),
      .csr_ack    (csr_ack),
      .csr_err    (csr_err),
      .acc_stb    (acc_stb),
      .acc_write  (acc_write),
      .acc_sel    (acc_sel),
      .acc_wdata  (acc_wdata)
   );

   mem_ss_csr_regs csr_regs_inst (
      .clk         (clk),
      .reset       (reset),
      .acc_stb     (acc_stb),
      .acc_write   (acc_write),
      .acc_sel     (acc_sel),
      .acc_wdata   (acc_wdata),
      .cal_success (cal_success),
      .cal_fail    (cal_fail),
      .rst_done    (rst_done),
      .rst_busy    (rst_busy),
      .csr_rdata   (csr_rdata),
      .restart     (restart)
   );

   mem_ss_rst_seq rst_seq_inst (
      .clk           (clk),
      .reset         (reset),
      .restart       (restart),
      .ss_rst_rdy    (ss_rst_rdy),
      .ss_rst_ack_n  (ss_rst_ack_n),
      .ss_rst_req    (ss_rst_req),
      .ss_cold_rst_n (ss_cold_rst_n),
      .rst_done      (rst_done),
      .rst_busy      (rst_busy)
   );

endmodule

//--- tb_mem_ss_properties.sv
// Protocol assertions for the memory subsystem control wrapper
// Register port handshake, reset handshake and known acknowledge,
// bound into every mem_ss_top

`timescale 1ns/1ns

module tb_mem_ss_properties (
   input logic                       clk,
   input logic                       reset,
   input logic                       csr_req,
   input logic                       csr_ack,
   input logic                       ss_rst_req,
   input logic                       ss_cold_rst_n
);

   ack_rise_with_req: assert property (@(posedge clk) disable iff (reset)
      $rose(csr_ack) |-> $past(csr_req))
      else $error("csr_ack rose without a pending csr_req");

   ack_fall_after_req: assert property (@(posedge clk) disable iff (reset)
      $fell(csr_ack) |-> !$past(csr_req))
      else $error("csr_ack fell while csr_req was still high");

   // Cold reset is only driven inside the request phase
   cold_inside_req: assert property (@(posedge clk) disable iff (reset)
      !ss_cold_rst_n |-> ss_rst_req)
      else $error("ss_cold_rst_n low while ss_rst_req is low");

   ack_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(csr_ack))
      else $error("csr_ack is unknown");

endmodule

bind mem_ss_top tb_mem_ss_properties props0 (
   .clk           (clk),
   .reset         (reset),
   .csr_req       (csr_req),
   .csr_ack       (csr_ack),
   .ss_rst_req    (ss_rst_req),
   .ss_cold_rst_n (ss_cold_rst_n)
);

//--- tb_mem_ss_checker.sv
// Response checker for the memory subsystem control wrapper
// Reference model of the register block, reset value and handshake
// order checks, per-test and closing reports

`timescale 1ns/1ns
`include "mem_ss_cfg.svh"

module tb_mem_ss_checker (
   input logic                       clk,
   input logic                       reset,
   input logic                       csr_req,
   input logic                       csr_write,
   input logic [`MEM_SS_ADDR_W-1:0]  csr_addr,
   input logic [`MEM_SS_DATA_W-1:0]  csr_wdata,
   input logic                       csr_ack,
   input logic [`MEM_SS_DATA_W-1:0]  csr_rdata,
   input logic                       csr_err,
   input logic                       ss_rst_req,
   input logic                       ss_cold_rst_n,
   input logic                       ss_rst_rdy,
   input logic                       ss_rst_ack_n,
   input logic [`MEM_SS_NUM_CH-1:0]  cal_success,
   input logic [`MEM_SS_NUM_CH-1:0]  cal_fail
);

   int checks = 0;
   int errors = 0;
   int tests = 0;
   int test_checks = 0;
   int test_errors = 0;

   logic                       req_q = 1'b0;
   logic                       ack_q = 1'b0;
   logic                       rst_req_q = 1'b0;
   logic                       cold_q = 1'b1;
   logic                       seen_rdy = 1'b0;
   logic                       seen_ack = 1'b0;
   logic                       exp_done = 1'b0;
   logic [`MEM_SS_DATA_W-1:0]  exp_scratch = '0;
   logic [`MEM_SS_ADDR_W-1:0]  cap_addr;
   logic                       cap_write;
   logic [`MEM_SS_DATA_W-1:0]  cap_wdata;
   logic [`MEM_SS_NUM_CH-1:0]  cap_cal_s;
   logic [`MEM_SS_NUM_CH-1:0]  cap_cal_f;
   logic                       cap_done;

   // Expected error flag and read word for one access
   function automatic logic [64:0] expect_word(
      input logic [2:0]  addr,
      input logic [63:0] scratch_v,
      input logic [3:0]  cal_s,
      input logic [3:0]  cal_f,
      input logic        done
   );
      mem_ss_csr_pkg::csr_word_u word;
      logic                      err;
      word.raw = '0;
      err      = 1'b0;
      case (addr)
         mem_ss_csr_pkg::CSR_DFH: begin
            word.raw[63:60] = `MEM_SS_FEAT_TYPE;
            word.raw[40]    = `MEM_SS_EOL;
            word.raw[39:16] = `MEM_SS_NEXT_DFH;
            word.raw[15:12] = `MEM_SS_FEAT_VER;
            word.raw[11:0]  = `MEM_SS_FEAT_ID;
         end
         mem_ss_csr_pkg::CSR_STATUS: begin
            word.raw[3:0]  = cal_s;
            word.raw[11:8] = cal_f;
            word.raw[16]   = done;
            word.raw[17]   = ~done;
         end
         mem_ss_csr_pkg::CSR_SCRATCH: word.raw = scratch_v;
         mem_ss_csr_pkg::CSR_CONTROL: word.raw = '0;
         default:                     err = 1'b1;
      endcase
      return {err, word.raw};
   endfunction

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      test_checks++;
      if (got !== exp) begin
         errors++;
         test_errors++;
         $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic note_error(input string msg);
      errors++;
      test_errors++;
      $display("%0t ns: %s", $time, msg);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("Test %0d %s: %0d checks, %0d errors", tests, name, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic report_counts();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
   endtask

   // ------------------------------------------------------------
   // Monitor, sampled on the falling edge
   // ------------------------------------------------------------

   always @(negedge clk) begin : compare
      logic [64:0] exp_word;
      if (reset) begin
         check_value("csr_ack", csr_ack, 64'd0);
         check_value("csr_err", csr_err, 64'd0);
         check_value("ss_rst_req", ss_rst_req, 64'd0);
         check_value("ss_cold_rst_n", ss_cold_rst_n, 64'd1);
         exp_scratch = '0;
         exp_done    = 1'b0;
      end else begin
         if (csr_req && !req_q) begin
            cap_addr  = csr_addr;
            cap_write = csr_write;
            cap_wdata = csr_wdata;
            cap_cal_s = cal_success;
            cap_cal_f = cal_fail;
            cap_done  = exp_done;
         end
         if (csr_ack && !ack_q) begin
            exp_word = expect_word(cap_addr, exp_scratch, cap_cal_s, cap_cal_f, cap_done);
            check_value("csr_err", csr_err, exp_word[64]);
            if (!cap_write) begin
               check_value("csr_rdata", csr_rdata, exp_word[63:0]);
            end else if (cap_addr == mem_ss_csr_pkg::CSR_SCRATCH) begin
               exp_scratch = cap_wdata;
            end
         end
         // Handshake order against the subsystem responses seen so far
         if (cold_q && !ss_cold_rst_n) begin
            check_value("ss_rst_rdy seen before cold reset", seen_rdy, 64'd1);
         end
         if (rst_req_q && !ss_rst_req) begin
            check_value("ss_rst_ack_n seen low before release", seen_ack, 64'd1);
            check_value("ss_cold_rst_n at release", ss_cold_rst_n, 64'd1);
         end
         if (ss_rst_req && !rst_req_q) begin
            seen_rdy = 1'b0;
            seen_ack = 1'b0;
         end
         if (ss_rst_rdy) seen_rdy = 1'b1;
         if (!ss_rst_ack_n) seen_ack = 1'b1;
         if (ss_rst_req) begin
            exp_done = 1'b0;
         end else if (ss_cold_rst_n && !ss_rst_rdy && ss_rst_ack_n) begin
            exp_done = 1'b1;
         end
      end
      req_q     = csr_req;
      ack_q     = csr_ack;
      rst_req_q = ss_rst_req;
      cold_q    = ss_cold_rst_n;
   end

endmodule

//--- tb_mem_ss_top.sv
// Testbench top for the memory subsystem control wrapper
// Clock, reset, random source, register port stimulus, subsystem
// reset handshake model and watchdog

`timescale 1ns/1ns
`include "mem_ss_cfg.svh"

module tb_mem_ss_top;

   localparam int CLK_PERIOD  = 40;
   localparam int DRIVE_DELAY = 5;
   // Six tests of up to 40 transactions, 20 cycles each
   localparam int WATCHDOG_CYCLES = 6 * 40 * 20;

   logic                       clk;
   logic                       reset;
   logic                       csr_req;
   logic                       csr_write;
   logic [`MEM_SS_ADDR_W-1:0]  csr_addr;
   logic [`MEM_SS_DATA_W-1:0]  csr_wdata;
   logic                       csr_ack;
   logic [`MEM_SS_DATA_W-1:0]  csr_rdata;
   logic                       csr_err;
   logic                       ss_rst_req;
   logic                       ss_cold_rst_n;
   logic                       ss_rst_rdy;
   logic                       ss_rst_ack_n;
   logic [`MEM_SS_NUM_CH-1:0]  cal_success;
   logic [`MEM_SS_NUM_CH-1:0]  cal_fail;
   logic [31:0]                lfsr = 32'hfe89_668c;

   mem_ss_top dut0 (
      .clk           (clk),
      .reset         (reset),
      .csr_req       (csr_req),
      .csr_write     (csr_write),
      .csr_addr      (csr_addr),
      .csr_wdata     (csr_wdata),
      .csr_ack       (csr_ack),
      .csr_rdata     (csr_rdata),
      .csr_err       (csr_err),
      .ss_rst_req    (ss_rst_req),
      .ss_cold_rst_n (ss_cold_rst_n),
      .ss_rst_rdy    (ss_rst_rdy),
      .ss_rst_ack_n  (ss_rst_ack_n),
      .cal_success   (cal_success),
      .cal_fail      (cal_fail)
   );

   tb_mem_ss_checker chk0 (
      .clk           (clk),
      .reset         (reset),
      .csr_req       (csr_req),
      .csr_write     (csr_write),
      .csr_addr      (csr_addr),
      .csr_wdata     (csr_wdata),
      .csr_ack       (csr_ack),
      .csr_rdata     (csr_rdata),
      .csr_err       (csr_err),
      .ss_rst_req    (ss_rst_req),
      .ss_cold_rst_n (ss_cold_rst_n),
      .ss_rst_rdy    (ss_rst_rdy),
      .ss_rst_ack_n  (ss_rst_ack_n),
      .cal_success   (cal_success),
      .cal_fail      (cal_fail)
   );

   // ------------------------------------------------------------
   // Clock, random source and watchdog
   // ------------------------------------------------------------

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // 32-bit Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[62:0], lfsr[0]};
      end
      return v;
   endfunction

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("Checks failed");
      $finish;
   end

   // ------------------------------------------------------------
   // Memory subsystem side of the reset handshake
   // ------------------------------------------------------------

   always begin : ss_model
      logic [63:0] r;
      int          delay;
      wait (ss_rst_req === 1'b1);
      r = rand_bits(2);
      delay = 1 + int'(r[1:0]);
      repeat (delay) @(posedge clk);
      #DRIVE_DELAY ss_rst_rdy = 1'b1;
      wait (ss_cold_rst_n === 1'b0);
      repeat (2) @(posedge clk);
      #DRIVE_DELAY ss_rst_ack_n = 1'b0;
      wait (ss_rst_req === 1'b0);
      @(posedge clk);
      #DRIVE_DELAY;
      ss_rst_rdy   = 1'b0;
      ss_rst_ack_n = 1'b1;
   end

   // ------------------------------------------------------------
   // Register port master
   // ------------------------------------------------------------

   // Every stimulus step ends just after a rising edge
   task automatic step(input int n);
      repeat (n) @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic csr_access(input logic w, input logic [2:0] a, input logic [63:0] d);
      int n;
      csr_req   = 1'b1;
      csr_write = w;
      csr_addr  = a;
      csr_wdata = d;
      n = 0;
      while (csr_ack !== 1'b1 && n < 10) begin
         step(1);
         n++;
      end
      if (csr_ack !== 1'b1) begin
         chk0.note_error("Register port did not acknowledge the request");
      end
      csr_req = 1'b0;
      n = 0;
      while (csr_ack !== 1'b0 && n < 10) begin
         step(1);
         n++;
      end
      if (csr_ack !== 1'b0) begin
         chk0.note_error("Register port held acknowledge after the request fell");
      end
   endtask

   // Waits for a full handshake with the subsystem model
   task automatic wait_handshake();
      int n;
      n = 0;
      while (ss_rst_req !== 1'b1 && n < 20) begin
         step(1);
         n++;
      end
      if (ss_rst_req !== 1'b1) begin
         chk0.note_error("Subsystem reset request never rose");
      end
      n = 0;
      while (!(ss_rst_req === 1'b0 && ss_rst_rdy === 1'b0 && ss_rst_ack_n === 1'b1)
             && n < 40) begin
         step(1);
         n++;
      end
      if (n == 40) begin
         chk0.note_error("Subsystem reset handshake did not complete");
      end
      step(2);
   endtask

   // ------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------

   initial begin : stimulus
      logic [63:0] data;
      reset        = 1'b1;
      csr_req      = 1'b0;
      csr_write    = 1'b0;
      csr_addr     = '0;
      csr_wdata    = '0;
      ss_rst_rdy   = 1'b0;
      ss_rst_ack_n = 1'b1;
      cal_success  = '0;
      cal_fail     = '0;
      repeat (2) @(posedge clk);
      #DRIVE_DELAY reset = 1'b0;
      chk0.end_test("reset values");

      wait_handshake();
      csr_access(1'b0, mem_ss_csr_pkg::CSR_STATUS, '0);
      chk0.end_test("power-up handshake");

      csr_access(1'b0, mem_ss_csr_pkg::CSR_DFH, '0);
      csr_access(1'b1, mem_ss_csr_pkg::CSR_DFH, rand_bits(64));
      csr_access(1'b0, mem_ss_csr_pkg::CSR_DFH, '0);
      chk0.end_test("feature header");

      for (int i = 0; i < 16; i++) begin
         data = rand_bits(64);
         csr_access(1'b1, mem_ss_csr_pkg::CSR_SCRATCH, data);
         csr_access(1'b0, mem_ss_csr_pkg::CSR_SCRATCH, '0);
      end
      chk0.end_test("scratch register");

      for (int i = 0; i < 12; i++) begin
         data = rand_bits(8);
         cal_success = data[3:0];
         cal_fail    = data[7:4];
         step(4);
         csr_access(1'b0, mem_ss_csr_pkg::CSR_STATUS, '0);
      end
      chk0.end_test("calibration status");

      for (int a = 4; a < 8; a++) begin
         csr_access(1'b0, a[2:0], '0);
         csr_access(1'b1, a[2:0], rand_bits(64));
      end
      csr_access(1'b0, mem_ss_csr_pkg::CSR_CONTROL, '0);
      csr_access(1'b1, mem_ss_csr_pkg::CSR_CONTROL, 64'h1);
      wait_handshake();
      csr_access(1'b0, mem_ss_csr_pkg::CSR_STATUS, '0);
      csr_access(1'b0, mem_ss_csr_pkg::CSR_SCRATCH, '0);
      chk0.end_test("unmapped addresses and restart");

      chk0.report_counts();
      if (chk0.errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- vlog.f
+incdir+.
mem_ss_csr_pkg.sv
mem_ss_rst_pkg.sv
mem_ss_csr_decode.sv
mem_ss_rst_seq.sv
mem_ss_csr_regs.sv
mem_ss_top.sv
tb_mem_ss_properties.sv
tb_mem_ss_checker.sv
tb_mem_ss_top.sv

//--- Bender.yml
package:
  name: mem_ss_ctrl

sources:
  - include_dirs:
      - .
    files:
      - mem_ss_csr_pkg.sv
      - mem_ss_rst_pkg.sv
      - mem_ss_csr_decode.sv
      - mem_ss_rst_seq.sv
      - mem_ss_csr_regs.sv
      - mem_ss_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_ss_properties.sv
      - tb_mem_ss_checker.sv
      - tb_mem_ss_top.sv
